/* source/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data and pc width
`define ID_XLEN 32

`define ID_NREG 32
`define ID_RADDR_W 5

// one-hot ALU operations
`define ID_ALU_OP_W 12

`define ID_MEM_TYPE_W 3

`endif

/* source/id_pkg.sv */
`include "id_settings.svh"

package id_pkg;

    // register-format view of an instruction word
    typedef struct packed {
        logic [5:0]             op_31_26;
        logic [3:0]             op_25_22;
        logic [1:0]             op_21_20;
        logic [4:0]             op_19_15;
        logic [`ID_RADDR_W-1:0] rk;
        logic [`ID_RADDR_W-1:0] rj;
        logic [`ID_RADDR_W-1:0] rd;
    } inst_r3_t;

    // immediate-format view, i16/i20/i26 are slices of this one
    typedef struct packed {
        logic [5:0]             op_31_26;
        logic [3:0]             op_25_22;
        logic [11:0]            i12;
        logic [`ID_RADDR_W-1:0] rj;
        logic [`ID_RADDR_W-1:0] rd;
    } inst_ri_t;

    typedef union packed {
        inst_r3_t r3;
        inst_ri_t ri;
    } inst_t;

    typedef struct packed {
        logic [`ID_XLEN-1:0] pc;
        inst_t               inst;
    } if_id_t;

    typedef struct packed {
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } br_t;

    typedef struct packed {
        logic                   bypass;  // valid register write in stage
        logic                   is_load; // EX only
        logic [`ID_RADDR_W-1:0] dest;
        logic [`ID_XLEN-1:0]    wdata;
    } fwd_t;

    typedef struct packed {
        logic                   we;
        logic [`ID_RADDR_W-1:0] waddr;
        logic [`ID_XLEN-1:0]    wdata;
    } wb_t;

    // bit 0 upward: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    typedef enum logic [`ID_MEM_TYPE_W-1:0] {
        MEM_WORD   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_BYTE   = 3'b010,
        MEM_HALF_U = 3'b101,
        MEM_BYTE_U = 3'b110
    } mem_type_e;

    typedef struct packed {
        alu_op_t                alu_op;
        mem_type_e              mem_type;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src_reg_is_rd;
        logic                   res_from_mem;
        logic                   gr_we;
        logic                   st_b;
        logic                   st_h;
        logic [`ID_RADDR_W-1:0] dest;
        logic                   need_addr1;
        logic                   need_addr2;
        logic                   beq, bne, blt, bge, bltu, bgeu;
        logic                   b, bl, jirl;
        logic                   need_ui5, need_si12, need_ui12;
        logic                   need_si20, need_si26, src2_is_4;
    } id_ctrl_t;

    typedef struct packed {
        logic                   gr_we;
        logic                   st_b;
        logic                   st_h;
        logic                   res_from_mem;
        mem_type_e              mem_type;
        alu_op_t                alu_op;
        logic [`ID_XLEN-1:0]    alu_src1;
        logic [`ID_XLEN-1:0]    alu_src2;
        logic [`ID_RADDR_W-1:0] dest;
        logic [`ID_XLEN-1:0]    rkd_value; // store data
        inst_t                  inst;
        logic [`ID_XLEN-1:0]    pc;
    } id_ex_t;

endpackage

/* source/id_decoder.sv */
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::inst_t    inst,
    output id_pkg::id_ctrl_t ctrl
);
    import id_pkg::*;

    logic [63:0] d_31_26;
    logic [15:0] d_25_22;
    logic [3:0]  d_21_20;
    logic [31:0] d_19_15;
    logic        r3_grp;
    logic        sh_grp;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor;
    logic        inst_and, inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic        inst_lu12i_w, inst_pcaddu12i;
    logic        inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic        inst_st_b, inst_st_h, inst_st_w;
    logic        is_load;
    logic        is_store;
    logic        is_cbr;

    // one-hot tables
    assign d_31_26 = 64'd1 << inst.r3.op_31_26;
    assign d_25_22 = 16'd1 << inst.r3.op_25_22;
    assign d_21_20 = 4'd1 << inst.r3.op_21_20;
    assign d_19_15 = 32'd1 << inst.r3.op_19_15;

    assign r3_grp = d_31_26[6'h00] & d_25_22[4'h0] & d_21_20[2'h1];
    assign sh_grp = d_31_26[6'h00] & d_25_22[4'h1] & d_21_20[2'h0]; // shift by ui5

    assign inst_add_w  = r3_grp & d_19_15[5'h00];
    assign inst_sub_w  = r3_grp & d_19_15[5'h02];
    assign inst_slt    = r3_grp & d_19_15[5'h04];
    assign inst_sltu   = r3_grp & d_19_15[5'h05];
    assign inst_nor    = r3_grp & d_19_15[5'h08];
    assign inst_and    = r3_grp & d_19_15[5'h09];
    assign inst_or     = r3_grp & d_19_15[5'h0a];
    assign inst_xor    = r3_grp & d_19_15[5'h0b];
    assign inst_sll_w  = r3_grp & d_19_15[5'h0e];
    assign inst_srl_w  = r3_grp & d_19_15[5'h0f];
    assign inst_sra_w  = r3_grp & d_19_15[5'h10];
    assign inst_slli_w = sh_grp & d_19_15[5'h01];
    assign inst_srli_w = sh_grp & d_19_15[5'h09];
    assign inst_srai_w = sh_grp & d_19_15[5'h11];

    assign inst_slti   = d_31_26[6'h00] & d_25_22[4'h8];
    assign inst_sltui  = d_31_26[6'h00] & d_25_22[4'h9];
    assign inst_addi_w = d_31_26[6'h00] & d_25_22[4'ha];
    assign inst_andi   = d_31_26[6'h00] & d_25_22[4'hd];
    assign inst_ori    = d_31_26[6'h00] & d_25_22[4'he];
    assign inst_xori   = d_31_26[6'h00] & d_25_22[4'hf];

    assign inst_lu12i_w   = d_31_26[6'h05] & ~inst.r3.op_25_22[3];
    assign inst_pcaddu12i = d_31_26[6'h07] & ~inst.r3.op_25_22[3];

    assign inst_ld_b  = d_31_26[6'h0a] & d_25_22[4'h0];
    assign inst_ld_h  = d_31_26[6'h0a] & d_25_22[4'h1];
    assign inst_ld_w  = d_31_26[6'h0a] & d_25_22[4'h2];
    assign inst_st_b  = d_31_26[6'h0a] & d_25_22[4'h4];
    assign inst_st_h  = d_31_26[6'h0a] & d_25_22[4'h5];
    assign inst_st_w  = d_31_26[6'h0a] & d_25_22[4'h6];
    assign inst_ld_bu = d_31_26[6'h0a] & d_25_22[4'h8];
    assign inst_ld_hu = d_31_26[6'h0a] & d_25_22[4'h9];

    assign ctrl.jirl = d_31_26[6'h13];
    assign ctrl.b    = d_31_26[6'h14];
    assign ctrl.bl   = d_31_26[6'h15];
    assign ctrl.beq  = d_31_26[6'h16];
    assign ctrl.bne  = d_31_26[6'h17];
    assign ctrl.blt  = d_31_26[6'h18];
    assign ctrl.bge  = d_31_26[6'h19];
    assign ctrl.bltu = d_31_26[6'h1a];
    assign ctrl.bgeu = d_31_26[6'h1b];

    assign is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store = inst_st_b | inst_st_h | inst_st_w;
    assign is_cbr   = ctrl.beq | ctrl.bne | ctrl.blt | ctrl.bge | ctrl.bltu | ctrl.bgeu;

    // address calc and link both go through add
    assign ctrl.alu_op[0]  = inst_add_w | inst_addi_w | is_load | is_store
                           | ctrl.jirl | ctrl.bl | inst_pcaddu12i;
    assign ctrl.alu_op[1]  = inst_sub_w;
    assign ctrl.alu_op[2]  = inst_slt | inst_slti;
    assign ctrl.alu_op[3]  = inst_sltu | inst_sltui;
    assign ctrl.alu_op[4]  = inst_and | inst_andi;
    assign ctrl.alu_op[5]  = inst_nor;
    assign ctrl.alu_op[6]  = inst_or | inst_ori;
    assign ctrl.alu_op[7]  = inst_xor | inst_xori;
    assign ctrl.alu_op[8]  = inst_sll_w | inst_slli_w;
    assign ctrl.alu_op[9]  = inst_srl_w | inst_srli_w;
    assign ctrl.alu_op[10] = inst_sra_w | inst_srai_w;
    assign ctrl.alu_op[11] = inst_lu12i_w;

    assign ctrl.mem_type = (inst_ld_h | inst_st_h) ? MEM_HALF   :
                           inst_ld_hu              ? MEM_HALF_U :
                           (inst_ld_b | inst_st_b) ? MEM_BYTE   :
                           inst_ld_bu              ? MEM_BYTE_U : MEM_WORD;

    assign ctrl.need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign ctrl.need_si12 = inst_addi_w | inst_slti | inst_sltui | is_load | is_store;
    assign ctrl.need_ui12 = inst_andi | inst_ori | inst_xori;
    assign ctrl.need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign ctrl.need_si26 = ctrl.b | ctrl.bl;
    assign ctrl.src2_is_4 = ctrl.jirl | ctrl.bl; // link value pc+4

    assign ctrl.src1_is_pc    = ctrl.jirl | ctrl.bl | inst_pcaddu12i;
    assign ctrl.src2_is_imm   = ctrl.need_ui5 | ctrl.need_si12 | ctrl.need_ui12
                              | ctrl.need_si20 | ctrl.src2_is_4;
    assign ctrl.src_reg_is_rd = is_store | is_cbr;
    assign ctrl.res_from_mem  = is_load;
    assign ctrl.gr_we         = ~(is_store | is_cbr | ctrl.b);
    assign ctrl.st_b          = inst_st_b;
    assign ctrl.st_h          = inst_st_h;
    assign ctrl.dest          = ctrl.bl ? 5'd1 : inst.r3.rd;

    assign ctrl.need_addr1 = r3_grp | sh_grp | inst_addi_w | inst_slti | inst_sltui
                           | inst_andi | inst_ori | inst_xori | is_load | is_store
                           | is_cbr | ctrl.jirl;
    assign ctrl.need_addr2 = r3_grp | is_store | is_cbr;

endmodule

/* source/id_imm_gen.sv */
`timescale 1ns/1ps
`include "id_settings.svh"

module id_imm_gen (
    input  id_pkg::inst_t       inst,
    input  id_pkg::id_ctrl_t    ctrl,
    output logic [`ID_XLEN-1:0] imm,
    output logic [`ID_XLEN-1:0] br_offs,
    output logic [`ID_XLEN-1:0] jirl_offs
);
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign i12 = inst.ri.i12;
    assign i16 = {inst.ri.op_25_22, inst.ri.i12};
    assign i20 = {inst.ri.op_25_22[2:0], inst.ri.i12, inst.ri.rj};
    assign i26 = {inst.ri.rj, inst.ri.rd, i16}; // high bits sit in rj:rd

    assign imm = ctrl.src2_is_4 ? `ID_XLEN'd4 :
                 ctrl.need_si20 ? {i20, 12'b0} :
                 ctrl.need_ui5  ? {{(`ID_XLEN-5){1'b0}}, inst.r3.rk} :
                 ctrl.need_si12 ? {{(`ID_XLEN-12){i12[11]}}, i12} :
                 ctrl.need_ui12 ? {{(`ID_XLEN-12){1'b0}}, i12} :
                 '0;

    assign jirl_offs = {{(`ID_XLEN-18){i16[15]}}, i16, 2'b0};
    assign br_offs   = ctrl.need_si26 ? {{(`ID_XLEN-28){i26[25]}}, i26, 2'b0} : jirl_offs;

endmodule

/* source/id_regfile.sv */
`timescale 1ns/1ps
`include "id_settings.svh"

module id_regfile (
    input  logic                   clk,
    input  logic [`ID_RADDR_W-1:0] raddr1,
    output logic [`ID_XLEN-1:0]    rdata1,
    input  logic [`ID_RADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]    rdata2,
    input  id_pkg::wb_t            wb
);
    logic [`ID_XLEN-1:0] rf [`ID_NREG];

    always_ff @(posedge clk) begin
        if (wb.we) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    // r0 reads zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* source/id_operand_fwd.sv */
`timescale 1ns/1ps
`include "id_settings.svh"

module id_operand_fwd (
    input  id_pkg::inst_t          inst,
    input  id_pkg::id_ctrl_t       ctrl,
    input  id_pkg::fwd_t           ex_fwd,
    input  id_pkg::fwd_t           mem_fwd,
    input  id_pkg::wb_t            wb,
    input  logic [`ID_XLEN-1:0]    rdata1,
    input  logic [`ID_XLEN-1:0]    rdata2,
    output logic [`ID_RADDR_W-1:0] raddr1,
    output logic [`ID_RADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]    rj_value,
    output logic [`ID_XLEN-1:0]    rkd_value,
    output logic                   ready_go
);
    logic use1;
    logic use2;

    // EX, then MEM, then WB, then the array
    function automatic logic [`ID_XLEN-1:0] pick(input logic [`ID_RADDR_W-1:0] a,
                                                 input logic used,
                                                 input logic [`ID_XLEN-1:0] arr);
        logic [`ID_XLEN-1:0] v;
        v = arr;
        if (used) begin
            if (ex_fwd.bypass && ex_fwd.dest == a) begin
                v = ex_fwd.wdata;
            end else if (mem_fwd.bypass && mem_fwd.dest == a) begin
                v = mem_fwd.wdata;
            end else if (wb.we && wb.waddr == a) begin
                v = wb.wdata;
            end
        end
        return v;
    endfunction

    assign raddr1 = inst.r3.rj;
    assign raddr2 = ctrl.src_reg_is_rd ? inst.r3.rd : inst.r3.rk;

    assign use1 = ctrl.need_addr1 & (raddr1 != '0);
    assign use2 = ctrl.need_addr2 & (raddr2 != '0);

    always_comb begin
        rj_value  = pick(raddr1, use1, rdata1);
        rkd_value = pick(raddr2, use2, rdata2);
    end

    // load result not ready until MEM
    assign ready_go = ~(ex_fwd.is_load & ((use1 & (ex_fwd.dest == raddr1))
                                        | (use2 & (ex_fwd.dest == raddr2))));

endmodule

/* source/id_branch_unit.sv */
`timescale 1ns/1ps
`include "id_settings.svh"

module id_branch_unit (
    input  id_pkg::id_ctrl_t    ctrl,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic [`ID_XLEN-1:0] rj_value,
    input  logic [`ID_XLEN-1:0] rkd_value,
    input  logic [`ID_XLEN-1:0] br_offs,
    input  logic [`ID_XLEN-1:0] jirl_offs,
    input  logic                id_valid,
    input  logic                ready_go,
    output id_pkg::br_t         br
);
    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = rj_value == rkd_value;
    assign lt_s = $signed(rj_value) < $signed(rkd_value);
    assign lt_u = rj_value < rkd_value;

    assign cond = (ctrl.beq  &  eq)   | (ctrl.bne  & ~eq)
                | (ctrl.blt  &  lt_s) | (ctrl.bge  & ~lt_s)
                | (ctrl.bltu &  lt_u) | (ctrl.bgeu & ~lt_u)
                | ctrl.b | ctrl.bl | ctrl.jirl; // jumps always go

    // only a real, issuable slot may redirect fetch
    assign br.taken  = cond & id_valid & ready_go;
    assign br.target = ctrl.jirl ? rj_value + jirl_offs : pc + br_offs;

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage (
    input  logic           clk,
    input  logic           resetn,
    input  logic           if_id_valid,
    output logic           id_allowin,
    input  id_pkg::if_id_t if_id,
    output id_pkg::br_t    id_if,
    input  logic           ex_allowin,
    output logic           id_ex_valid,
    output id_pkg::id_ex_t id_ex,
    input  id_pkg::fwd_t   ex_fwd,
    input  id_pkg::fwd_t   mem_fwd,
    input  id_pkg::wb_t    wb
);
    import id_pkg::*;

    logic                   id_valid;
    logic                   ready_go;
    if_id_t                 if_id_q;
    id_ctrl_t               ctrl;
    logic [`ID_XLEN-1:0]    imm;
    logic [`ID_XLEN-1:0]    br_offs;
    logic [`ID_XLEN-1:0]    jirl_offs;
    logic [`ID_RADDR_W-1:0] raddr1;
    logic [`ID_RADDR_W-1:0] raddr2;
    logic [`ID_XLEN-1:0]    rdata1;
    logic [`ID_XLEN-1:0]    rdata2;
    logic [`ID_XLEN-1:0]    rj_value;
    logic [`ID_XLEN-1:0]    rkd_value;

    assign id_ex_valid = id_valid & ready_go;
    assign id_allowin  = ~id_valid | (id_ex_valid & ex_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (id_if.taken) begin
            id_valid <= 1'b0; // squash wrong-path slot
        end else if (id_allowin) begin
            id_valid <= if_id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_valid && id_allowin) begin
            if_id_q <= if_id;
        end
    end

    id_decoder u_decoder (
        .inst (if_id_q.inst),
        .ctrl (ctrl)
    );

    id_imm_gen u_imm_gen (
        .inst      (if_id_q.inst),
        .ctrl      (ctrl),
        .imm       (imm),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs)
    );

    id_regfile u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rdata1),
        .raddr2 (raddr2),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    id_operand_fwd u_operand_fwd (
        .inst      (if_id_q.inst),
        .ctrl      (ctrl),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb        (wb),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .ready_go  (ready_go)
    );

    id_branch_unit u_branch_unit (
        .ctrl      (ctrl),
        .pc        (if_id_q.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .id_valid  (id_valid),
        .ready_go  (ready_go),
        .br        (id_if)
    );

    always_comb begin
        id_ex.gr_we        = ctrl.gr_we;
        id_ex.st_b         = ctrl.st_b;
        id_ex.st_h         = ctrl.st_h;
        id_ex.res_from_mem = ctrl.res_from_mem;
        id_ex.mem_type     = ctrl.mem_type;
        id_ex.alu_op       = ctrl.alu_op;
        id_ex.alu_src1     = ctrl.src1_is_pc ? if_id_q.pc : rj_value;
        id_ex.alu_src2     = ctrl.src2_is_imm ? imm : rkd_value;
        id_ex.dest         = ctrl.dest;
        id_ex.rkd_value    = rkd_value;
        id_ex.inst         = if_id_q.inst;
        id_ex.pc           = if_id_q.pc;
    end

endmodule

/* verif/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int CLK_PERIOD = 40;
    // cycles per test: reset, regs, imm, fwd, load-use, branches, stall
    localparam int RUN_CYCLES = 6 + 12 + 20 + 10 + 6 + 72 + 8;

    logic   clk;
    logic   resetn;
    logic   if_id_valid;
    logic   id_allowin;
    if_id_t if_id;
    br_t    id_if;
    logic   ex_allowin;
    logic   id_ex_valid;
    id_ex_t id_ex;
    fwd_t   ex_fwd;
    fwd_t   mem_fwd;
    wb_t    wb;

    logic [31:0] seed = 32'hf4af99da;
    int          errors = 0;
    int          checks = 0;

    id_stage id_stage_i (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // 3R group word with op in bits 19:15
    function automatic logic [31:0] r3_word(logic [4:0] op, logic [4:0] rk, logic [4:0] rj,
                                            logic [4:0] rd);
        return {6'h00, 4'h0, 2'h1, op, rk, rj, rd};
    endfunction

    // op is bits 31:22
    function automatic logic [31:0] ri_word(logic [9:0] op, logic [11:0] i12, logic [4:0] rj,
                                            logic [4:0] rd);
        return {op, i12, rj, rd};
    endfunction

    function automatic logic [31:0] branch_word(logic [5:0] op, logic [15:0] offs,
                                                logic [4:0] rj, logic [4:0] rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br_offset(logic [15:0] o);
        return {{14{o[15]}}, o, 2'b00};
    endfunction

    function automatic logic taken_ref(logic [5:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            6'h16:   return a == b;
            6'h17:   return a != b;
            6'h18:   return $signed(a) < $signed(b);
            6'h19:   return $signed(a) >= $signed(b);
            6'h1a:   return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic expect_eq(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic write_reg(logic [4:0] addr, logic [31:0] data);
        tick();
        wb = {1'b1, addr, data};
        tick();
        wb = '0;
    endtask

    // returns 2 ns after the edge that latched the instruction
    task automatic issue(logic [31:0] pc, logic [31:0] inst);
        tick();
        if_id_valid = 1'b1;
        if_id = {pc, inst};
        #1;
        while (!id_allowin) tick();
        tick();
        if_id_valid = 1'b0;
    endtask

    task automatic reg_reads();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        write_reg(5'd1, a);
        write_reg(5'd2, b);
        write_reg(5'd0, next_rand());
        issue(32'h1c00_0000, r3_word(5'h00, 5'd2, 5'd1, 5'd3)); // add.w r3,r1,r2
        #5;
        expect_eq("id_ex_valid", id_ex_valid, 1);
        expect_eq("alu_src1", id_ex.alu_src1, a);
        expect_eq("alu_src2", id_ex.alu_src2, b);
        expect_eq("dest", id_ex.dest, 3);
        expect_eq("gr_we", id_ex.gr_we, 1);
        expect_eq("add.w alu_op", id_ex.alu_op, 12'h001);
        expect_eq("pc", id_ex.pc, 32'h1c00_0000);
        issue(32'h1c00_0004, r3_word(5'h00, 5'd2, 5'd0, 5'd3));
        #5;
        expect_eq("alu_src1 r0", id_ex.alu_src1, 0);
    endtask

    task automatic imm_controls();
        logic [31:0] v;
        v = next_rand();
        write_reg(5'd4, v);
        write_reg(5'd6, ~v);
        issue(32'h1c00_0100, ri_word(10'h00a, 12'hffd, 5'd4, 5'd5)); // addi.w
        #5;
        expect_eq("addi.w alu_src1", id_ex.alu_src1, v);
        expect_eq("addi.w alu_src2", id_ex.alu_src2, {{20{1'b1}}, 12'hffd});
        issue(32'h1c00_0104, ri_word(10'h00d, 12'hf80, 5'd4, 5'd5)); // andi
        #5;
        expect_eq("andi alu_src2", id_ex.alu_src2, {20'h0, 12'hf80});
        expect_eq("andi alu_op", id_ex.alu_op, 12'h010);
        issue(32'h1c00_0108, {6'h00, 4'h1, 2'h0, 5'h01, 5'd17, 5'd4, 5'd5}); // slli.w
        #5;
        expect_eq("slli.w alu_src2", id_ex.alu_src2, 32'd17);
        expect_eq("slli.w alu_op", id_ex.alu_op, 12'h100);
        issue(32'h1c00_010c, {7'h0a, 20'h81234, 5'd5}); // lu12i.w
        #5;
        expect_eq("lu12i.w alu_src2", id_ex.alu_src2, {20'h81234, 12'h0});
        expect_eq("lu12i.w alu_op", id_ex.alu_op, 12'h800);
        issue(32'h1c00_0110, {7'h0e, 20'h00001, 5'd5}); // pcaddu12i
        #5;
        expect_eq("pcaddu12i alu_src1", id_ex.alu_src1, 32'h1c00_0110);
        expect_eq("pcaddu12i alu_src2", id_ex.alu_src2, 32'h0000_1000);
        issue(32'h1c00_0114, ri_word(10'h0a8, 12'h008, 5'd4, 5'd5)); // ld.bu
        #5;
        expect_eq("mem_type", id_ex.mem_type, 3'b110);
        expect_eq("res_from_mem", id_ex.res_from_mem, 1);
        issue(32'h1c00_0118, ri_word(10'h0a5, 12'h004, 5'd4, 5'd6)); // st.h
        #5;
        expect_eq("st_h", id_ex.st_h, 1);
        expect_eq("gr_we", id_ex.gr_we, 0);
        expect_eq("rkd_value", id_ex.rkd_value, ~v);
        issue(32'h1c00_011c, ri_word(10'h0a4, 12'h001, 5'd4, 5'd6)); // st.b
        #5;
        expect_eq("st_b", id_ex.st_b, 1);
        expect_eq("st.b mem_type", id_ex.mem_type, 3'b010);
    endtask

    task automatic fwd_priority();
        logic [31:0] e;
        logic [31:0] m;
        logic [31:0] w;
        e = next_rand();
        m = next_rand();
        w = next_rand();
        issue(32'h1c00_0200, r3_word(5'h00, 5'd7, 5'd7, 5'd9)); // add.w r9,r7,r7
        ex_fwd = {1'b1, 1'b0, 5'd7, e};
        mem_fwd = {1'b1, 1'b0, 5'd7, m};
        wb = {1'b1, 5'd7, w};
        #5;
        expect_eq("alu_src1 from EX", id_ex.alu_src1, e);
        tick();
        ex_fwd.bypass = 1'b0;
        #5;
        expect_eq("alu_src1 from MEM", id_ex.alu_src1, m);
        tick();
        mem_fwd.bypass = 1'b0;
        wb.wdata = ~w; // array already holds w
        #5;
        expect_eq("alu_src2 from WB", id_ex.alu_src2, ~w);
        issue(32'h1c00_0204, r3_word(5'h00, 5'd7, 5'd0, 5'd9)); // add.w r9,r0,r7
        ex_fwd = {1'b1, 1'b0, 5'd0, e};
        mem_fwd = {1'b1, 1'b0, 5'd0, m};
        wb = {1'b1, 5'd0, e};
        #5;
        expect_eq("alu_src1 r0 fwd", id_ex.alu_src1, 0);
        expect_eq("alu_src2 r7", id_ex.alu_src2, ~w); // array took the last WB write
        tick();
        ex_fwd = '0;
        mem_fwd = '0;
        wb = '0;
    endtask

    task automatic load_use_stall();
        logic [31:0] v;
        v = next_rand();
        issue(32'h1c00_0300, r3_word(5'h00, 5'd0, 5'd11, 5'd10)); // add.w r10,r11,r0
        ex_fwd = {1'b1, 1'b1, 5'd11, 32'h0};
        repeat (2) begin
            #5;
            expect_eq("id_ex_valid load-use", id_ex_valid, 0);
            expect_eq("id_allowin load-use", id_allowin, 0);
            tick();
        end
        ex_fwd = {1'b1, 1'b0, 5'd11, v};
        #5;
        expect_eq("id_ex_valid released", id_ex_valid, 1);
        expect_eq("id_allowin released", id_allowin, 1);
        expect_eq("alu_src1 after stall", id_ex.alu_src1, v);
        tick();
        ex_fwd = '0;
    endtask

    task automatic branch_cases();
        logic [31:0] a [3];
        logic [31:0] b [3];
        logic [31:0] pc;
        logic [31:0] j;
        logic [5:0]  op;
        logic [2:0]  k;
        logic        want;
        int          p;
        a = '{32'h5a5a_0001, 32'hffff_fff0, 32'h0000_0010};
        b = '{32'h5a5a_0001, 32'h0000_0010, 32'hffff_fff0};
        pc = 32'h1c00_1000;
        for (p = 0; p < 3; p++) begin
            write_reg(5'd12, a[p]);
            write_reg(5'd13, b[p]);
            for (k = 0; k < 6; k++) begin
                op = 6'h16 + {3'b0, k};
                want = taken_ref(op, a[p], b[p]);
                issue(pc, branch_word(op, 16'hfff3, 5'd12, 5'd13));
                if_id_valid = 1'b1; // wrong-path fetch
                if_id = {pc + 32'd4, r3_word(5'h00, 5'd0, 5'd0, 5'd0)};
                #5;
                expect_eq("id_if.taken", id_if.taken, want);
                expect_eq("id_if.target", id_if.target, pc + br_offset(16'hfff3));
                tick();
                if_id_valid = 1'b0;
                #5;
                expect_eq("id_ex_valid after branch", id_ex_valid, !want);
                pc = pc + 32'h40;
            end
        end
        j = next_rand();
        write_reg(5'd14, j);
        issue(pc, branch_word(6'h13, 16'h0010, 5'd14, 5'd1)); // jirl r1,r14,0x40
        #5;
        expect_eq("jirl taken", id_if.taken, 1);
        expect_eq("jirl target", id_if.target, j + br_offset(16'h0010));
        issue(pc + 32'd4, {6'h15, 16'hfffe, 10'h3ff}); // bl back 8 bytes
        #5;
        expect_eq("bl taken", id_if.taken, 1);
        expect_eq("bl target", id_if.target, pc - 32'd4);
        expect_eq("bl dest", id_ex.dest, 1);
        expect_eq("bl alu_src2", id_ex.alu_src2, 4);
    endtask

    task automatic back_pressure();
        logic [31:0] cur;
        logic [31:0] nxt;
        cur = r3_word(5'h00, 5'd2, 5'd1, 5'd3); // add.w r3,r1,r2
        nxt = r3_word(5'h0a, 5'd2, 5'd1, 5'd8); // or r8,r1,r2
        issue(32'h1c00_2000, cur);
        ex_allowin = 1'b0;
        if_id_valid = 1'b1;
        if_id = {32'h1c00_2004, nxt};
        tick();
        repeat (3) begin
            #5;
            expect_eq("id_allowin stalled", id_allowin, 0);
            expect_eq("id_ex.inst held", id_ex.inst, cur);
            expect_eq("id_ex.pc held", id_ex.pc, 32'h1c00_2000);
            tick();
        end
        ex_allowin = 1'b1;
        #5;
        expect_eq("id_allowin resumed", id_allowin, 1);
        tick();
        if_id_valid = 1'b0;
        #5;
        expect_eq("id_ex.inst", id_ex.inst, nxt);
        expect_eq("id_ex.pc", id_ex.pc, 32'h1c00_2004);
        expect_eq("or alu_op", id_ex.alu_op, 12'h040);
        expect_eq("id_ex_valid resumed", id_ex_valid, 1);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 2);
        $display("timeout: tests did not finish within %0d cycles", RUN_CYCLES * 2);
        $display("Verification failed");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        if_id_valid = 1'b0;
        if_id = '0;
        ex_allowin = 1'b1;
        ex_fwd = '0;
        mem_fwd = '0;
        wb = '0;
        repeat (5) @(posedge clk);
        #2;
        resetn = 1'b1;
        #5;
        expect_eq("id_ex_valid after reset", id_ex_valid, 0);
        expect_eq("id_if.taken after reset", id_if.taken, 0);
        expect_eq("id_allowin after reset", id_allowin, 1);
        reg_reads();
        imm_controls();
        fwd_priority();
        load_use_stall();
        branch_cases();
        back_pressure();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/id_pkg.sv
source/id_decoder.sv
source/id_imm_gen.sv
source/id_regfile.sv
source/id_operand_fwd.sv
source/id_branch_unit.sv
source/id_stage.sv
verif/tb_id_stage.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_id_stage -Mdir obj_dir \
    > build.log 2>&1 &&
./obj_dir/Vtb_id_stage > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
